// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_bus_slave
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_bus_slave.sv
`timescale 1ns/10ps

module tb_bus_slave;

	import bus_slave_pkg::*;

	localparam int wait_limit = 400;

	logic                   clk;
	logic                   reset;
	logic [delay_width-1:0] slave_delay;
	logic                   read_en;
	logic                   write_en;
	logic                   master_valid;
	logic                   master_ready;
	logic                   rx_address;
	logic                   rx_data;
	logic                   rx_burst;
	logic                   slave_ready;
	logic                   slave_valid;
	logic                   tx_data;
	logic                   split_en;

	// Expected memory contents
	logic [data_width-1:0] ref_mem [mem_depth];

	integer seed;
	int     data_errors;
	int     proto_errors;
	int     timeouts;
	bit     ready_gaps;
	bit     valid_gaps;

	tb_clock u_clock (
		.clk (clk)
	);

	bus_slave u_dut (
		.clk          (clk),
		.reset        (reset),
		.slave_delay  (slave_delay),
		.read_en      (read_en),
		.write_en     (write_en),
		.master_valid (master_valid),
		.master_ready (master_ready),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.rx_burst     (rx_burst),
		.slave_ready  (slave_ready),
		.slave_valid  (slave_valid),
		.tx_data      (tx_data),
		.split_en     (split_en)
	);

	task automatic log_protocol_error(input string what);
		proto_errors++;
		$display("Protocol error: %s", what);
	endtask

	task automatic report_timeout(input string name, input string what);
		timeouts++;
		$display("Timeout in %s: %s", name, what);
	endtask

	task automatic check_value(input string name, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		assert (actual === expected)
		else
		begin
			data_errors++;
			$display("CHECK FAILED %s: expected %02h, actual %02h", name, expected, actual);
		end
	endtask

	// ==============================
	// Protocol checks
	// ==============================
	a_reset_state: assert property (
		@(posedge clk) $fell(reset) |-> (!slave_valid && !split_en && slave_ready)
	) else log_protocol_error("slave not idle after reset");

	a_split_valid_apart: assert property (
		@(posedge clk) disable iff (reset)
		!(split_en && slave_valid)
	) else log_protocol_error("split_en and slave_valid high in the same cycle");

	a_split_only_slow: assert property (
		@(posedge clk) disable iff (reset)
		split_en |-> (slave_delay >= split_threshold)
	) else log_protocol_error("split_en raised for a delay below the threshold");

	a_tx_hold: assert property (
		@(posedge clk) disable iff (reset)
		(slave_valid && !master_ready) |=> $stable(tx_data)
	) else log_protocol_error("tx_data changed while stalled");

	a_no_ready_in_read: assert property (
		@(posedge clk) disable iff (reset)
		slave_valid |-> !slave_ready
	) else log_protocol_error("slave_ready high while sending read data");

	// Ends one cycle after slave_ready is seen at the wanted level
	task automatic wait_ready(input logic level, input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (slave_ready !== level && cycles < wait_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (slave_ready !== level)
			report_timeout(name, "slave_ready never reached the expected level");
		@(posedge clk);
		#1;
	endtask

	task automatic drive_beat(input logic a, input logic d, input logic b, input string name);
		if (valid_gaps && ({$random(seed)} % 4 == 0))
		begin
			master_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		master_valid = 1'b1;
		rx_address   = a;
		rx_data      = d;
		rx_burst     = b;
		wait_ready(1'b1, name);
	endtask

	function automatic logic [burst_width-1:0] burst_field(input int count);
		logic [burst_width-2:0] count_m1;
		count_m1 = count - 1;
		if (count > 1)
			return {count_m1, 1'b1};
		else
			return '0;
	endfunction

	task automatic send_header(input logic [addr_width-1:0] base, input int count,
		input string name);
		logic [burst_width-1:0] burst;
		burst = burst_field(count);
		for (int i = 0; i < header_beats; i++)
			drive_beat((i < addr_width) ? base[i] : 1'($random(seed)), 1'b0, burst[i], name);
		master_valid = 1'b0;
	endtask

	task automatic write_words(input logic [addr_width-1:0] base, input int count,
		input string name);
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] word;
		addr     = base;
		write_en = 1'b1;
		read_en  = 1'b0;
		send_header(base, count, name);
		for (int w = 0; w < count; w++)
		begin
			word          = $random(seed);
			ref_mem[addr] = word;
			for (int i = 0; i < data_width; i++)
				drive_beat(1'b0, word[i], 1'b0, name);
			addr = addr + 1'b1;
		end
		master_valid = 1'b0;
		// Finish cycle drops slave_ready once
		wait_ready(1'b0, name);
		wait_ready(1'b1, name);
		write_en = 1'b0;
	endtask

	task automatic read_words(input logic [addr_width-1:0] base, input int count,
		input logic [delay_width-1:0] delay, input string name);
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] word;
		int                    bits;
		int                    words;
		int                    cycles;
		bit                    saw_split;
		bit                    saw_valid;
		addr        = base;
		word        = '0;
		bits        = 0;
		words       = 0;
		cycles      = 0;
		saw_split   = 1'b0;
		saw_valid   = 1'b0;
		slave_delay = delay;
		read_en     = 1'b1;
		write_en    = 1'b0;
		send_header(base, count, name);
		while (words < count && cycles < wait_limit)
		begin
			@(negedge clk);
			if (split_en)
				saw_split = 1'b1;
			if (slave_valid && !saw_valid)
			begin
				saw_valid = 1'b1;
				check_value({name, " split"}, delay >= split_threshold, saw_split);
			end
			if (slave_valid && master_ready)
			begin
				word = {tx_data, word[data_width-1:1]};
				bits++;
				if (bits == data_width)
				begin
					check_value(name, ref_mem[addr], word);
					addr   = addr + 1'b1;
					bits   = 0;
					cycles = 0;
					words++;
				end
			end
			@(posedge clk);
			#1;
			master_ready = ready_gaps ? ({$random(seed)} % 4 != 0) : 1'b1;
			cycles++;
		end
		if (words < count)
			report_timeout(name, "read data stopped before the last word");
		// No extra word after the burst
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk);
			check_value({name, " valid after burst"}, 1'b0, slave_valid);
		end
		check_value({name, " ready after burst"}, 1'b1, slave_ready);
		@(posedge clk);
		#1;
		read_en      = 1'b0;
		master_ready = 1'b1;
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial
	begin
		logic [addr_width-1:0]  addr;
		logic [delay_width-1:0] delay;
		int                     count;
		seed         = 32'h2236;
		reset        = 1'b1;
		slave_delay  = '0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		master_valid = 1'b0;
		master_ready = 1'b1;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
		rx_burst     = 1'b0;
		data_errors  = 0;
		proto_errors = 0;
		timeouts     = 0;
		ready_gaps   = 1'b0;
		valid_gaps   = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;

		addr = $random(seed);
		write_words(addr, 1, "single write");
		read_words(addr, 1, 2, "single read");

		// Burst wraps past the top address
		write_words(12'hffd, 6, "burst write");
		read_words(12'hffd, 6, 0, "burst read");

		delay = split_threshold - 1;
		read_words(12'hffd, 3, delay, "fast read");
		delay = split_threshold;
		read_words(12'hffd, 3, delay, "slow read");
		read_words(12'hffe, 2, 17, "long slow read");

		// Stalls on both directions
		ready_gaps = 1'b1;
		valid_gaps = 1'b1;
		for (int t = 0; t < 8; t++)
		begin
			addr  = $random(seed);
			count = 1 + {$random(seed)} % 8;
			delay = {$random(seed)} % 12;
			write_words(addr, count, "random write");
			read_words(addr, count, delay, "random read");
		end

		$display("Errors: data %0d, protocol %0d, timeout %0d",
			data_errors, proto_errors, timeouts);
		if (data_errors == 0 && proto_errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	localparam real half_period = 4.0;

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

endmodule

// File: design/bus_slave.sv
`timescale 1ns/10ps

module bus_slave (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [bus_slave_pkg::delay_width-1:0] slave_delay,
	input  logic                                 read_en,
	input  logic                                 write_en,
	input  logic                                 master_valid,
	input  logic                                 master_ready,
	input  logic                                 rx_address,
	input  logic                                 rx_data,
	input  logic                                 rx_burst,
	output logic                                 slave_ready,
	output logic                                 slave_valid,
	output logic                                 tx_data,
	output logic                                 split_en
);

	import bus_slave_pkg::*;

	logic [addr_width-1:0] address;
	logic [data_width-1:0] wr_data;
	logic [data_width-1:0] rd_data;
	logic                  wr_strobe;
	logic                  header_done;
	logic                  next_word;
	logic                  txn_end;
	logic                  rd_en;
	logic                  load;
	logic                  tx_done;

	// ==============================
	// Serial port blocks
	// ==============================
	slave_in_port u_in (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.slave_ready  (slave_ready),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.next_word    (next_word),
		.txn_end      (txn_end),
		.address      (address),
		.wr_data      (wr_data),
		.wr_strobe    (wr_strobe),
		.header_done  (header_done)
	);

	// slave_ready loops back so the controller sees the same inbound handshake
	slave_port u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.slave_delay    (slave_delay),
		.read_en        (read_en),
		.write_en       (write_en),
		.rx_burst       (rx_burst),
		.master_valid   (master_valid),
		.header_done    (header_done),
		.wr_strobe      (wr_strobe),
		.tx_done        (tx_done),
		.slave_ready_in (slave_ready),
		.slave_valid    (slave_valid),
		.split_en       (split_en),
		.rd_en          (rd_en),
		.load           (load),
		.next_word      (next_word),
		.txn_end        (txn_end),
		.slave_ready    (slave_ready)
	);

	slave_out_port u_out (
		.clk          (clk),
		.reset        (reset),
		.load         (load),
		.rd_data      (rd_data),
		.slave_valid  (slave_valid),
		.master_ready (master_ready),
		.tx_data      (tx_data),
		.tx_done      (tx_done)
	);

	slave_memory u_mem (
		.clk       (clk),
		.wr_strobe (wr_strobe),
		.address   (address),
		.wr_data   (wr_data),
		.rd_en     (rd_en),
		.rd_data   (rd_data)
	);

endmodule

// File: design/bus_slave_pkg.sv
package bus_slave_pkg;

	// Bus widths
	localparam int addr_width  = 12;
	localparam int data_width  = 8;
	localparam int burst_width = 13;
	localparam int delay_width = 6;

	// Header length and slow-slave split point
	localparam int header_beats    = 13;
	localparam int split_threshold = 5;

	localparam int mem_depth = 4096;

	// Counter widths
	localparam int hdr_cnt_width = $clog2(header_beats + 1);
	localparam int bit_cnt_width = $clog2(data_width);

	// ==============================
	// Controller states
	// ==============================
	localparam int state_width = 3;

	localparam logic [state_width-1:0] st_idle   = 3'd0;
	localparam logic [state_width-1:0] st_write  = 3'd1;
	localparam logic [state_width-1:0] st_wait   = 3'd2;
	localparam logic [state_width-1:0] st_fetch  = 3'd3;
	localparam logic [state_width-1:0] st_valid  = 3'd4;
	localparam logic [state_width-1:0] st_finish = 3'd5;

endpackage

// File: design/slave_in_port.sv
`timescale 1ns/10ps

module slave_in_port (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                master_valid,
	input  logic                                slave_ready,
	input  logic                                read_en,
	input  logic                                write_en,
	input  logic                                rx_address,
	input  logic                                rx_data,
	input  logic                                next_word,
	input  logic                                txn_end,
	output logic [bus_slave_pkg::addr_width-1:0] address,
	output logic [bus_slave_pkg::data_width-1:0] wr_data,
	output logic                                wr_strobe,
	output logic                                header_done
);

	import bus_slave_pkg::*;

	logic [hdr_cnt_width-1:0] hdr_cnt;
	logic [bit_cnt_width-1:0] bit_cnt;
	logic                     beat;
	logic                     in_header;
	logic                     data_beat;

	// Accepted inbound beat
	assign beat      = master_valid && slave_ready && (read_en || write_en);
	assign in_header = (hdr_cnt < header_beats);
	assign data_beat = beat && !in_header && write_en;

	assign header_done = beat && (hdr_cnt == header_beats - 1);

	// ==============================
	// Beat counters
	// ==============================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			hdr_cnt   <= '0;
			bit_cnt   <= '0;
			wr_strobe <= 1'b0;
		end
		else if (txn_end)
		begin
			hdr_cnt   <= '0;
			bit_cnt   <= '0;
			wr_strobe <= 1'b0;
		end
		else
		begin
			// Strobe lands one cycle after the last bit of a word
			wr_strobe <= data_beat && (bit_cnt == data_width - 1);
			if (beat && in_header)
				hdr_cnt <= hdr_cnt + 1'b1;
			if (data_beat)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// ==============================
	// Word address
	// ==============================
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			address <= '0;
		end
		else if (beat && (hdr_cnt < addr_width))
		begin
			// LSB first, beat 13 carries no address bit
			address <= {rx_address, address[addr_width-1:1]};
		end
		else if (wr_strobe || next_word)
		begin
			address <= address + 1'b1;
		end
	end

	// Write data shifter
	always_ff @(posedge clk)
	begin
		if (data_beat)
			wr_data <= {rx_data, wr_data[data_width-1:1]};
	end

	// Past the header only write data may come in
	a_data_beat_write: assert property (
		@(posedge clk) disable iff (reset)
		(beat && !in_header) |-> write_en
	) else $error("inbound beat after the header of a read");

endmodule

// File: design/slave_memory.sv
`timescale 1ns/10ps

module slave_memory (
	input  logic                                clk,
	input  logic                                wr_strobe,
	input  logic [bus_slave_pkg::addr_width-1:0] address,
	input  logic [bus_slave_pkg::data_width-1:0] wr_data,
	input  logic                                rd_en,
	output logic [bus_slave_pkg::data_width-1:0] rd_data
);

	import bus_slave_pkg::*;

	// ==============================
	// Byte array
	// ==============================
	logic [data_width-1:0] mem [mem_depth];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_strobe)
			mem[address] <= wr_data;
	end

	// Registered read, data valid the cycle after rd_en
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[address];
	end

endmodule

// File: design/slave_out_port.sv
`timescale 1ns/10ps

module slave_out_port (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                load,
	input  logic [bus_slave_pkg::data_width-1:0] rd_data,
	input  logic                                slave_valid,
	input  logic                                master_ready,
	output logic                                tx_data,
	output logic                                tx_done
);

	import bus_slave_pkg::*;

	logic [data_width-1:0]    shift_reg;
	logic [bit_cnt_width-1:0] beat_cnt;
	logic                     beat;

	assign beat    = slave_valid && master_ready;
	assign tx_data = shift_reg[0];

	// Last bit of the word goes out this cycle
	assign tx_done = beat && (beat_cnt == data_width - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			beat_cnt <= '0;
		else if (load)
			beat_cnt <= '0;
		else if (beat)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// ==============================
	// Output shifter, LSB first
	// ==============================
	always_ff @(posedge clk)
	begin
		if (load)
			shift_reg <= rd_data;
		else if (beat)
			shift_reg <= {1'b0, shift_reg[data_width-1:1]};
	end

	// Stall must hold the bit on the wire
	a_tx_stable: assert property (
		@(posedge clk) disable iff (reset)
		(slave_valid && !master_ready) |=> $stable(tx_data)
	) else $error("tx_data moved while master_ready was low");

endmodule

// File: design/slave_port.sv
`timescale 1ns/10ps

module slave_port (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [bus_slave_pkg::delay_width-1:0] slave_delay,
	input  logic                                 read_en,
	input  logic                                 write_en,
	input  logic                                 rx_burst,
	input  logic                                 master_valid,
	input  logic                                 header_done,
	input  logic                                 wr_strobe,
	input  logic                                 tx_done,
	input  logic                                 slave_ready_in,
	output logic                                 slave_valid,
	output logic                                 split_en,
	output logic                                 rd_en,
	output logic                                 load,
	output logic                                 next_word,
	output logic                                 txn_end,
	output logic                                 slave_ready
);

	import bus_slave_pkg::*;

	logic [state_width-1:0] state;
	logic [burst_width-1:0] burst;
	logic [burst_width-2:0] word_cnt;
	logic [delay_width-1:0] delay_q;
	logic [delay_width-1:0] wait_cnt;
	logic                   fetch_load;
	logic                   hdr_beat;
	logic                   last_word;

	assign hdr_beat = (state == st_idle) && master_valid && slave_ready_in &&
		(read_en || write_en);

	// Single transfers stop after one word
	assign last_word = !burst[0] || (word_cnt == burst[burst_width-1:1]);

	// ==============================
	// Outputs decoded from state
	// ==============================
	assign slave_ready = (state == st_idle) || (state == st_write);
	assign slave_valid = (state == st_valid);
	assign split_en    = (state == st_wait) && (delay_q >= split_threshold);
	assign rd_en       = (state == st_fetch) && !fetch_load;
	assign load        = (state == st_fetch) && fetch_load;
	assign next_word   = (state == st_valid) && tx_done && !last_word;
	assign txn_end     = (state == st_finish);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= st_idle;
			burst      <= '0;
			word_cnt   <= '0;
			delay_q    <= '0;
			wait_cnt   <= '0;
			fetch_load <= 1'b0;
		end
		else
		begin
			// Burst field rides on the header beats, LSB first
			if (hdr_beat)
				burst <= {rx_burst, burst[burst_width-1:1]};

			case (state)
				st_idle:
				begin
					if (header_done)
					begin
						word_cnt   <= '0;
						wait_cnt   <= '0;
						delay_q    <= slave_delay;
						fetch_load <= 1'b0;
						if (write_en)
							state <= st_write;
						else if (slave_delay == '0)
							state <= st_fetch;
						else
							state <= st_wait;
					end
				end
				st_write:
				begin
					if (wr_strobe)
					begin
						if (last_word)
							state <= st_finish;
						else
							word_cnt <= word_cnt + 1'b1;
					end
				end
				st_wait:
				begin
					if (wait_cnt == delay_q - 1'b1)
						state <= st_fetch;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				st_fetch:
				begin
					// rd_en cycle, then load once rd_data is out
					if (fetch_load)
					begin
						fetch_load <= 1'b0;
						state      <= st_valid;
					end
					else
					begin
						fetch_load <= 1'b1;
					end
				end
				st_valid:
				begin
					if (tx_done)
					begin
						if (last_word)
						begin
							state <= st_finish;
						end
						else
						begin
							word_cnt <= word_cnt + 1'b1;
							state    <= st_fetch;
						end
					end
				end
				st_finish:
				begin
					state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Write words only complete inside the write phase
	a_strobe_in_write: assert property (
		@(posedge clk) disable iff (reset)
		wr_strobe |-> (state == st_write)
	) else $error("write strobe outside the write phase");

endmodule

// File: verilog.f
design/bus_slave_pkg.sv
design/slave_in_port.sv
design/slave_out_port.sv
design/slave_port.sv
design/slave_memory.sv
design/bus_slave.sv
bench/tb_clock.sv
bench/tb_bus_slave.sv
